//--- dsp16_seq.f
common/dsp16_pkg.sv
common/seq_ctl_if.sv
logic/prog_rom.sv
logic/instr_decode.sv
rom_aau/rom_aau.sv
logic/dsp16_seq.sv
test/dsp16_seq_props.sv
test/dsp16_seq_tb.sv

//--- test/dsp16_seq_tb.sv
`timescale 1ns/10ps

module dsp16_seq_tb;

    localparam int ROM_AW     = 8;
    localparam int ROM_WORDS  = 2 ** ROM_AW;
    localparam int RST_CYCLES = 8;
    localparam int RUN_WALK   = 300;
    localparam int RUN_DIRECT = 403;
    localparam int RUN_INDIR  = 400;
    localparam int RUN_TABLE  = 400;
    localparam int RUN_ICALL  = 51;
    localparam int RUN_GATED  = 1000;
    // Six tests, each with a reset and a full ROM load
    localparam int PLAN_CYCLES = 6 * (RST_CYCLES + ROM_WORDS) + RUN_WALK + RUN_DIRECT
        + RUN_INDIR + RUN_TABLE + RUN_ICALL + RUN_GATED;
    localparam int TIMEOUT_NS = PLAN_CYCLES * 40 * 2;

    localparam logic [3:0] OPC_GOTO  = 4'h1;
    localparam logic [3:0] OPC_CALL  = 4'h2;
    localparam logic [3:0] OPC_BR    = 4'h3;
    localparam logic [3:0] OPC_LOAD  = 4'h4;
    localparam logic [3:0] OPC_STEP  = 4'h5;
    localparam logic [3:0] OPC_ICALL = 4'h6;
    localparam logic [3:0] OPC_HALT  = 4'h7;

    // Program mixes
    localparam int MIX_NOP    = 0;
    localparam int MIX_DIRECT = 1;
    localparam int MIX_INDIR  = 2;
    localparam int MIX_TABLE  = 3;
    localparam int MIX_FULL   = 4;

    logic              clk;
    logic              rst;
    logic              cen;
    logic              load_en;
    logic [ROM_AW-1:0] load_addr;
    logic [15:0]       load_data;
    logic [15:0]       pc;
    logic [15:0]       pr;
    logic [15:0]       pi;
    logic [15:0]       pt;
    logic [11:0]       i_reg;
    logic [15:0]       instr;

    // Reference model state
    logic [15:0] m_rom [0:ROM_WORDS-1];
    logic [15:0] prog [0:ROM_WORDS-1];
    logic [15:0] m_pc;
    logic [15:0] m_pr;
    logic [15:0] m_pi;
    logic [15:0] m_pt;
    logic [11:0] m_i;

    dsp16_seq #(
        .ROM_AW     (ROM_AW)
    ) dut0 (
        .clk        (clk),
        .rst        (rst),
        .cen        (cen),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .pc         (pc),
        .pr         (pr),
        .pi         (pi),
        .pt         (pt),
        .i_reg      (i_reg),
        .instr      (instr)
    );

    always #20 clk = ~clk;

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped by the watchdog");
    end

    task automatic check_equal(input string what, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Value mismatch on %s", what);
        end
    endtask

    task automatic check_state();
        check_equal("instr", instr, m_rom[m_pc[ROM_AW-1:0]]);
        check_equal("pc", pc, m_pc);
        check_equal("pr", pr, m_pr);
        check_equal("pi", pi, m_pi);
        check_equal("pt", pt, m_pt);
        check_equal("i_reg", {4'd0, i_reg}, {4'd0, m_i});
    endtask

    // One enabled cycle of the sequencer as the rules describe it
    task automatic model_exec();
        logic [15:0] w;
        logic [15:0] seq;
        logic [11:0] inc;
        w   = m_rom[m_pc[ROM_AW-1:0]];
        seq = m_pc + 16'd1;
        inc = w[0] ? m_i : 12'd1;
        case (w[15:12])
            OPC_GOTO: m_pc = {m_pc[15:12], w[11:0]};
            OPC_CALL: begin
                m_pr = seq;
                m_pc = {m_pc[15:12], w[11:0]};
            end
            OPC_BR: begin
                case (w[9:8])
                    2'd0: m_pc = m_pr;
                    2'd1: m_pc = m_pi;
                    2'd2: m_pc = m_pt;
                    default: begin
                        m_pr = seq;
                        m_pc = m_pt;
                    end
                endcase
            end
            OPC_LOAD: begin
                case (w[11:10])
                    2'd0: m_pt = {6'd0, w[9:0]};
                    2'd1: m_pr = {6'd0, w[9:0]};
                    2'd2: m_pi = {6'd0, w[9:0]};
                    default: m_i = {2'd0, w[9:0]};
                endcase
                m_pc = seq;
            end
            OPC_STEP: begin
                m_pt = {m_pt[15:12], m_pt[11:0] + inc};   // Wraps in 12 bits
                m_pc = seq;
            end
            OPC_ICALL: begin
                m_pi = seq;
                m_pc = 16'd2;
            end
            OPC_HALT: begin
                // pc stays put
            end
            default: m_pc = seq;
        endcase
    endtask

    // Check, drive on the falling edge, advance the model, wait a cycle
    task automatic step(input logic cen_v, input logic ld_en,
                        input logic [ROM_AW-1:0] ld_addr, input logic [15:0] ld_data);
        check_state();
        cen       = cen_v;
        load_en   = ld_en;
        load_addr = ld_addr;
        load_data = ld_data;
        if (cen_v) begin
            model_exec();
        end
        if (ld_en) begin
            m_rom[ld_addr] = ld_data;
        end
        @(negedge clk);
    endtask

    task automatic apply_reset();
        rst     = 1'b1;
        cen     = 1'b0;
        load_en = 1'b0;
        repeat (RST_CYCLES) @(negedge clk);
        rst  = 1'b0;
        m_pc = '0;
        m_pr = '0;
        m_pi = '0;
        m_pt = '0;
        m_i  = '0;
    endtask

    function automatic logic [3:0] nop_code();
        int k;
        k = $urandom_range(8);
        return (k == 0) ? 4'h0 : 4'(k + 7);     // Zero or unused codes 8 to 15
    endfunction

    function automatic logic [15:0] gen_word(input int mix);
        logic [15:0] r;
        int          pick;
        r    = $urandom;
        pick = $urandom_range(99);
        case (mix)
            MIX_DIRECT: r[15:12] = (pick < 35) ? OPC_GOTO : (pick < 70) ? OPC_CALL : nop_code();
            MIX_INDIR: begin
                if (pick < 40) begin
                    r[15:12] = OPC_LOAD;
                    r[11:10] = 2'($urandom_range(2));   // pt, pr or pi
                end else if (pick < 70) begin
                    r[15:12] = OPC_BR;
                end else begin
                    r[15:12] = nop_code();
                end
            end
            MIX_TABLE: begin
                if (pick < 60) begin
                    r[15:12] = OPC_STEP;
                end else if (pick < 80) begin
                    r[15:12] = OPC_LOAD;
                    r[11:10] = pick[0] ? 2'd3 : 2'd0;   // i or pt
                end else begin
                    r[15:12] = nop_code();
                end
            end
            MIX_FULL: begin
                if (r[15:12] == OPC_HALT) begin
                    r[15:12] = 4'h8;    // A halt would end the walk
                end
            end
            default: r[15:12] = nop_code();
        endcase
        return r;
    endfunction

    task automatic fill_prog(input int mix);
        for (int a = 0; a < ROM_WORDS; a++) begin
            prog[a] = gen_word(mix);
        end
    endtask

    task automatic load_prog();
        for (int a = 0; a < ROM_WORDS; a++) begin
            step(1'b0, 1'b1, a[ROM_AW-1:0], prog[a]);
        end
    endtask

    task automatic run(input int n, input int low_pct);
        for (int k = 0; k < n; k++) begin
            step($urandom_range(99) >= low_pct, 1'b0, '0, '0);
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        cen       = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        void'($urandom(41201));
        for (int a = 0; a < ROM_WORDS; a++) begin
            m_rom[a] = '0;
        end

        // Reset, load and a plain walk through NOP words
        apply_reset();
        fill_prog(MIX_NOP);
        load_prog();
        run(RUN_WALK, 0);

        // Direct branches, first rolling pc into the next 4K page
        apply_reset();
        fill_prog(MIX_DIRECT);
        prog[0]           = {OPC_GOTO, 12'hFFF};
        prog[ROM_WORDS-1] = 16'h0000;
        load_prog();
        run(2, 0);
        step(1'b0, 1'b1, '0, {OPC_CALL, 12'($urandom)});
        run(RUN_DIRECT - 3, 0);

        apply_reset();
        fill_prog(MIX_INDIR);
        load_prog();
        run(RUN_INDIR, 0);

        // Table pointer, seeded with i and pt loads
        apply_reset();
        fill_prog(MIX_TABLE);
        prog[0] = {OPC_LOAD, 2'd3, 10'h3FF};
        prog[1] = {OPC_LOAD, 2'd0, 10'($urandom)};
        for (int a = 2; a < 7; a++) begin
            prog[a] = {OPC_STEP, 11'($urandom), 1'b1};   // Five steps by i force a 12 bit wrap
        end
        load_prog();
        run(RUN_TABLE, 0);

        // goto 10, icall, iret back to 11, then halt at 12
        apply_reset();
        fill_prog(MIX_NOP);
        prog[0]  = {OPC_GOTO, 12'h00A};
        prog[10] = {OPC_ICALL, 12'($urandom)};
        prog[3]  = {OPC_BR, 2'($urandom), 2'd1, 8'($urandom)};
        prog[12] = {OPC_HALT, 12'($urandom)};
        load_prog();
        run(30, 0);
        step(1'b0, 1'b1, 8'd12, {OPC_GOTO, 12'h040});
        run(RUN_ICALL - 31, 0);

        // Fully random program under random enable
        apply_reset();
        fill_prog(MIX_FULL);
        load_prog();
        run(RUN_GATED, 30);
        check_state();

        if (dut0.aau0.props0.assert_fails == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            $display("TEST RESULT: FAIL");
            $fatal(1, "Assertion failures were seen during the run");
        end
    end

endmodule

//--- test/dsp16_seq_props.sv
`timescale 1ns/10ps

module dsp16_seq_props (
    input logic             clk,
    input logic             rst,
    input logic             cen,
    input logic             goto_ja,
    input logic             call_ja,
    input logic             goto_b,
    input logic             load_imm,
    input logic             pt_step,
    input logic             icall,
    input logic             halt,
    input dsp16_pkg::addr_t pc,
    input dsp16_pkg::addr_t pt
);

    int unsigned assert_fails = 0;     // Read by the testbench at the end

    a_one_strobe: assert property (@(posedge clk) disable iff (rst)
        $onehot0({goto_ja, call_ja, goto_b, load_imm, pt_step, icall, halt}))
    else begin
        assert_fails++;
        $error("More than one instruction strobe is high");
    end

    // Disabled cycle freezes the fetch address
    a_cen_hold: assert property (@(posedge clk) disable iff (rst)
        !cen |=> $stable(pc))
    else begin
        assert_fails++;
        $error("pc moved in a cycle with cen low");
    end

    a_halt_hold: assert property (@(posedge clk) disable iff (rst)
        (cen && halt) |=> $stable(pc))
    else begin
        assert_fails++;
        $error("pc moved on a halt instruction");
    end

    a_pt_page: assert property (@(posedge clk) disable iff (rst)
        (cen && pt_step) |=> (pt[15:12] == $past(pt[15:12])))
    else begin
        assert_fails++;
        $error("Top bits of pt changed on a pointer step");
    end

endmodule

bind rom_aau dsp16_seq_props props0 (
    .clk        (clk),
    .rst        (rst),
    .cen        (cen),
    .goto_ja    (ctl.goto_ja),
    .call_ja    (ctl.call_ja),
    .goto_b     (ctl.goto_b),
    .load_imm   (ctl.load_imm),
    .pt_step    (ctl.pt_step),
    .icall      (ctl.icall),
    .halt       (ctl.halt),
    .pc         (pc),
    .pt         (pt)
);

//--- logic/dsp16_seq.sv
`timescale 1ns/10ps

module dsp16_seq #(
    parameter int ROM_AW = 8
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,
    // Host program load, only while cen is low
    input  logic                load_en,
    input  logic [ROM_AW-1:0]   load_addr,
    input  dsp16_pkg::word_t    load_data,
    // Register view
    output dsp16_pkg::addr_t    pc,
    output dsp16_pkg::addr_t    pr,
    output dsp16_pkg::addr_t    pi,
    output dsp16_pkg::addr_t    pt,
    output dsp16_pkg::ifield_t  i_reg,
    output dsp16_pkg::word_t    instr
);

    dsp16_pkg::addr_t rom_addr;

    seq_ctl_if ctl ();

    prog_rom #(
        .ROM_AW     (ROM_AW)
    ) rom0 (
        .clk        (clk),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .rom_addr   (rom_addr),
        .instr      (instr)
    );

    // Decodes the word fetched in this same cycle
    instr_decode dec0 (
        .instr      (instr),
        .ctl        (ctl.dec)
    );

    rom_aau aau0 (
        .clk        (clk),
        .rst        (rst),
        .cen        (cen),
        .ctl        (ctl.aau),
        .rom_addr   (rom_addr),
        .pc         (pc),
        .pr         (pr),
        .pi         (pi),
        .pt         (pt),
        .i_reg      (i_reg)
    );

endmodule

//--- rom_aau/rom_aau.sv
`timescale 1ns/10ps

// ROM address arithmetic unit
module rom_aau (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,
    seq_ctl_if.aau              ctl,
    output dsp16_pkg::addr_t    rom_addr,
    output dsp16_pkg::addr_t    pc,
    output dsp16_pkg::addr_t    pr,
    output dsp16_pkg::addr_t    pi,
    output dsp16_pkg::addr_t    pt,
    output dsp16_pkg::ifield_t  i_reg
);

    dsp16_pkg::addr_t   seq_pc;     // Shared incrementer
    dsp16_pkg::addr_t   next_pc;
    dsp16_pkg::addr_t   next_pt;
    dsp16_pkg::ifield_t pt_inc;
    dsp16_pkg::addr_t   imm_ext;

    logic ret;
    logic iret;
    logic goto_pt;
    logic call_pt;
    logic copy_pc;
    logic load_pt;
    logic load_pr;
    logic load_pi;
    logic load_i;

    assign seq_pc = pc + 16'd1;
    assign imm_ext = {6'd0, ctl.imm};

    // Indirect branch group
    assign ret     = ctl.goto_b && (ctl.bsel == dsp16_pkg::B_RET);
    assign iret    = ctl.goto_b && (ctl.bsel == dsp16_pkg::B_IRET);
    assign goto_pt = ctl.goto_b && (ctl.bsel == dsp16_pkg::B_GOTO_PT);
    assign call_pt = ctl.goto_b && (ctl.bsel == dsp16_pkg::B_CALL_PT);
    assign copy_pc = ctl.call_ja || call_pt;

    // Immediate load targets
    assign load_pt = ctl.load_imm && (ctl.rsel == dsp16_pkg::R_PT);
    assign load_pr = ctl.load_imm && (ctl.rsel == dsp16_pkg::R_PR);
    assign load_pi = ctl.load_imm && (ctl.rsel == dsp16_pkg::R_PI);
    assign load_i  = ctl.load_imm && (ctl.rsel == dsp16_pkg::R_I);

    // Single 12 bit pointer adder, top of pt is kept
    assign pt_inc  = ctl.istep ? i_reg : 12'd1;
    assign next_pt = {pt[15:12], pt[11:0] + pt_inc};

    always_comb begin
        if (ctl.icall) begin
            next_pc = dsp16_pkg::ICALL_VECTOR;
        end else if (ctl.goto_ja || ctl.call_ja) begin
            next_pc = {pc[15:12], ctl.i_field};   // Stay in the 4K page
        end else if (goto_pt || call_pt) begin
            next_pc = pt;
        end else if (ret) begin
            next_pc = pr;
        end else if (iret) begin
            next_pc = pi;
        end else if (ctl.halt) begin
            next_pc = pc;
        end else begin
            next_pc = seq_pc;
        end
    end

    assign rom_addr = pc;   // Fetch always from pc

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc    <= '0;
            pr    <= '0;
            pi    <= '0;
            pt    <= '0;
            i_reg <= '0;
        end else if (cen) begin
            pc <= next_pc;

            if (copy_pc) begin
                pr <= seq_pc;             // Return address for calls
            end else if (load_pr) begin
                pr <= imm_ext;
            end

            if (ctl.icall) begin
                pi <= seq_pc;
            end else if (load_pi) begin
                pi <= imm_ext;
            end

            if (ctl.pt_step) begin
                pt <= next_pt;
            end else if (load_pt) begin
                pt <= imm_ext;
            end

            if (load_i) begin
                i_reg <= {2'd0, ctl.imm};
            end
        end
    end

endmodule

//--- logic/instr_decode.sv
`timescale 1ns/10ps

module instr_decode (
    input  dsp16_pkg::word_t instr,
    seq_ctl_if.dec           ctl
);

    dsp16_pkg::opcode_t op;

    assign op = dsp16_pkg::opcode_t'(instr[15:12]);

    // Field slices are passed on every cycle, strobes qualify them
    assign ctl.i_field = instr[11:0];
    assign ctl.bsel    = dsp16_pkg::bsel_t'(instr[9:8]);
    assign ctl.rsel    = dsp16_pkg::rsel_t'(instr[11:10]);
    assign ctl.imm     = instr[9:0];
    assign ctl.istep   = instr[0];

    always_comb begin
        ctl.goto_ja  = 1'b0;
        ctl.call_ja  = 1'b0;
        ctl.goto_b   = 1'b0;
        ctl.load_imm = 1'b0;
        ctl.pt_step  = 1'b0;
        ctl.icall    = 1'b0;
        ctl.halt     = 1'b0;

        case (op)
            dsp16_pkg::OP_GOTO_JA: begin
                ctl.goto_ja = 1'b1;
            end
            dsp16_pkg::OP_CALL_JA: begin
                ctl.call_ja = 1'b1;
            end
            dsp16_pkg::OP_GOTO_B: begin
                ctl.goto_b = 1'b1;     // Return, iret or pt branches
            end
            dsp16_pkg::OP_LOAD_IMM: begin
                ctl.load_imm = 1'b1;
            end
            dsp16_pkg::OP_PT_STEP: begin
                ctl.pt_step = 1'b1;
            end
            dsp16_pkg::OP_ICALL: begin
                ctl.icall = 1'b1;
            end
            dsp16_pkg::OP_HALT: begin
                ctl.halt = 1'b1;
            end
            default: begin
                // NOP and codes 8 to 15 raise nothing
            end
        endcase
    end

endmodule

//--- logic/prog_rom.sv
`timescale 1ns/10ps

module prog_rom #(
    parameter int ROM_AW = 8
) (
    input  logic                clk,
    input  logic                load_en,
    input  logic [ROM_AW-1:0]   load_addr,
    input  dsp16_pkg::word_t    load_data,
    input  dsp16_pkg::addr_t    rom_addr,
    output dsp16_pkg::word_t    instr
);

    localparam int DEPTH = 2 ** ROM_AW;

    dsp16_pkg::word_t mem [0:DEPTH-1];
    logic [ROM_AW-1:0] rd_addr;

    // Erased memory reads as NOP
    initial begin
        for (int k = 0; k < DEPTH; k++) begin
            mem[k] = '0;
        end
    end

    // Host write port
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    // Only the low address bits index the array
    assign rd_addr = rom_addr[ROM_AW-1:0];

    // Combinational read so the word is there in its own fetch cycle
    assign instr = mem[rd_addr];

endmodule

//--- common/seq_ctl_if.sv
`timescale 1ns/10ps

interface seq_ctl_if;

    // One-hot instruction strobes, all low for a NOP
    logic goto_ja;
    logic call_ja;
    logic goto_b;
    logic load_imm;
    logic pt_step;
    logic icall;
    logic halt;

    // Instruction fields
    dsp16_pkg::bsel_t   bsel;
    dsp16_pkg::rsel_t   rsel;
    dsp16_pkg::ifield_t i_field;
    dsp16_pkg::imm_t    imm;
    logic               istep;     // Step pt by i instead of one

    modport dec (
        output goto_ja, call_ja, goto_b, load_imm, pt_step, icall, halt,
        output bsel, rsel, i_field, imm, istep
    );

    modport aau (
        input goto_ja, call_ja, goto_b, load_imm, pt_step, icall, halt,
        input bsel, rsel, i_field, imm, istep
    );

endinterface

//--- common/dsp16_pkg.sv
package dsp16_pkg;

    typedef logic [15:0] word_t;    // Instruction or register word
    typedef logic [15:0] addr_t;    // Program or table address
    typedef logic [11:0] ifield_t;  // Direct branch field, also i and low pt
    typedef logic [ 9:0] imm_t;     // Short immediate

    // Instruction bits 15 to 12
    typedef enum logic [3:0] {
        OP_NOP      = 4'd0,
        OP_GOTO_JA  = 4'd1,
        OP_CALL_JA  = 4'd2,
        OP_GOTO_B   = 4'd3,
        OP_LOAD_IMM = 4'd4,
        OP_PT_STEP  = 4'd5,
        OP_ICALL    = 4'd6,
        OP_HALT     = 4'd7
    } opcode_t;

    // Indirect branch group, bits 9 to 8
    typedef enum logic [1:0] {
        B_RET     = 2'd0,
        B_IRET    = 2'd1,
        B_GOTO_PT = 2'd2,
        B_CALL_PT = 2'd3
    } bsel_t;

    // Register select, bits 11 to 10
    typedef enum logic [1:0] {
        R_PT = 2'd0,
        R_PR = 2'd1,
        R_PI = 2'd2,
        R_I  = 2'd3
    } rsel_t;

    localparam addr_t ICALL_VECTOR = 16'd2;   // Software interrupt entry

endpackage
